// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= branch_pred_tb
FLIST     ?= branch_pred.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD VFLAGS"

$(BUILD)/V$(TOP): $(FLIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

test: $(BUILD)/V$(TOP)
	@out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== bp_defs.svh ====
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// fetch PC width
`define BP_PC_W 64
// bytes per instruction line
`define BP_LINE_BYTES 64
// slots predecoded per line, 32-bit each
`define BP_SLOTS 4
// global history length
`define BP_GHR_K 8
// pc bits in the pht index, taken from pc[9:2]
`define BP_PHT_N 8
// return address stack entries
`define BP_RAS_DEPTH 8
// direct-mapped l0 sets
`define BP_L0_SETS 8
// where fetch starts out of reset
`define BP_RESET_PC 64'h0

`endif

// ==== bp_pkg.sv ====
`include "bp_defs.svh"

package bp_pkg;

  // instruction address
  typedef logic [`BP_PC_W-1:0] pc_t;

  // single 32-bit instruction word
  typedef logic [31:0] instr_t;

  // whole line, byte 0 sits in bits 7..0
  typedef logic [`BP_LINE_BYTES*8-1:0] line_t;

  // 2-bit saturating counter, 0 strongly not-taken .. 3 strongly taken
  typedef logic [1:0] ctr_t;

  // global history, newest outcome in bit 0
  typedef logic [`BP_GHR_K-1:0] ghr_t;

  // {history, pc[9:2]}
  typedef logic [`BP_GHR_K+`BP_PHT_N-1:0] pht_idx_t;

  // one bit per slot, slot 0 in bit 0
  typedef logic [`BP_SLOTS-1:0] slot_mask_t;

  // fetch FSM
  typedef enum logic [1:0] {
    FS_REQ  = 2'd0, // send l1 request
    FS_WAIT = 2'd1, // l1 request outstanding
    FS_L0   = 2'd2  // line streams out of l0
  } fetch_state_t;

endpackage

// ==== bp_predecode_if.sv ====
`timescale 1ns/1ps

interface bp_predecode_if import bp_pkg::*; ();

  // controller side, line under scan
  pc_t        fetch_pc;
  line_t      line;
  pc_t        ras_top;    // current return address guess
  slot_mask_t slot_pred;  // gshare says taken, per slot

  // predecoder side, results
  pc_t        next_pc;
  slot_mask_t br_mask;    // slot holds a decoded branch
  slot_mask_t taken_mask; // slot ends the fetch group
  logic       ras_push;
  logic       ras_pop;
  pc_t        push_addr;  // BL return address

  // purely combinational, no handshake
  modport ctrl (
    output fetch_pc, line, ras_top, slot_pred,
    input  next_pc, br_mask, taken_mask, ras_push, ras_pop, push_addr
  );

  modport dec (
    input  fetch_pc, line, ras_top, slot_pred,
    output next_pc, br_mask, taken_mask, ras_push, ras_pop, push_addr
  );

endinterface

// ==== branch_pred.f ====
+incdir+.
bp_pkg.sv
bp_predecode_if.sv
ras_stack.sv
l0_icache.sv
gshare_pht.sv
branch_predecode.sv
branch_pred.sv
tb_clkgen.sv
branch_pred_assert.sv
branch_pred_tb.sv

// ==== branch_pred.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module branch_pred import bp_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_N_in,
  input  logic        l1i_valid,
  input  line_t       l1i_line,
  input  logic        x_bcond_resolved,
  input  logic        x_taken,
  input  pc_t         x_pc,
  input  logic        x_pc_incorrect,
  input  logic [18:0] x_correction_offset,
  output pc_t         pred_pc,
  output logic        pc_valid,
  output line_t       fetch_line,
  output slot_mask_t  br_mask,
  output slot_mask_t  taken_mask,
  output logic        l0_valid,
  output logic        l1i_req,
  output pc_t         l1i_addr
);

  fetch_state_t state, state_nxt;
  pc_t   pc;           // current fetch pc
  pc_t   redirect_pc;
  pc_t   req_addr;     // line address of the outstanding request
  line_t l0_line_q;    // line captured on an l0 hit
  line_t cur_line;
  logic  drop, drop_nxt; // discard the next l1 return
  logic  req_pending;
  logic  line_avail;
  logic  proc;         // a line is predecoded this cycle
  logic  l0_hit;
  line_t l0_hit_line;

  bp_predecode_if pd_if ();

  assign redirect_pc = x_pc + {{(`BP_PC_W-19){x_correction_offset[18]}}, x_correction_offset};
  assign l1i_addr    = {pc[`BP_PC_W-1:6], 6'b0}; // line aligned

  assign line_avail  = ((state == FS_WAIT) && l1i_valid && !drop) || (state == FS_L0);
  assign proc        = line_avail && !x_pc_incorrect; // redirect kills this cycle's group
  assign cur_line    = (state == FS_L0) ? l0_line_q : l1i_line;
  // request in flight, includes the one going out right now
  assign req_pending = (state == FS_WAIT) || ((state == FS_REQ) && l1i_req);

  assign pd_if.fetch_pc = pc;
  assign pd_if.line     = cur_line;

  always_comb begin
    state_nxt = state;
    drop_nxt  = drop;
    case (state)
      FS_REQ:  if (l1i_req) state_nxt = FS_WAIT;
      FS_WAIT: begin
        if (l1i_valid && drop) begin
          drop_nxt  = 1'b0; // stale line swallowed
          state_nxt = FS_REQ;
        end else if (l1i_valid) begin
          state_nxt = l0_hit ? FS_L0 : FS_REQ;
        end
      end
      FS_L0:   state_nxt = l0_hit ? FS_L0 : FS_REQ;
      default: state_nxt = FS_REQ;
    endcase
    if (x_pc_incorrect) begin
      if (req_pending && !l1i_valid) begin
        drop_nxt  = 1'b1; // wait out the old return first
        state_nxt = FS_WAIT;
      end else begin
        drop_nxt  = 1'b0;
        state_nxt = FS_REQ;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      state    <= FS_REQ;
      pc       <= `BP_RESET_PC;
      drop     <= 1'b0;
      l1i_req  <= 1'b0;
      pc_valid <= 1'b0;
      l0_valid <= 1'b0;
    end else begin
      state    <= state_nxt;
      drop     <= drop_nxt;
      l1i_req  <= (state_nxt == FS_REQ); // one pulse per entry into FS_REQ
      pc_valid <= proc;
      l0_valid <= proc && (state == FS_L0);
      if (x_pc_incorrect) pc <= redirect_pc;
      else if (proc)      pc <= pd_if.next_pc;
    end
  end

  // payload, qualified by pc_valid and the FSM
  always_ff @(posedge clk_in) begin
    if (l1i_req) req_addr <= l1i_addr;
    if (proc && l0_hit) l0_line_q <= l0_hit_line;
    if (proc) begin
      pred_pc    <= pd_if.next_pc;
      fetch_line <= cur_line;
      br_mask    <= pd_if.br_mask;
      taken_mask <= pd_if.taken_mask;
    end
  end

  ras_stack #(.DEPTH(`BP_RAS_DEPTH)) ras_i (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .push     (proc && pd_if.ras_push), // only when a line really went through
    .pop      (proc && pd_if.ras_pop),
    .push_addr(pd_if.push_addr),
    .top      (pd_if.ras_top)
  );

  l0_icache #(.SETS(`BP_L0_SETS)) l0_i (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .fill     ((state == FS_WAIT) && l1i_valid), // dropped lines are still good data
    .fill_addr(req_addr),
    .fill_line(l1i_line),
    .lookup_pc(pd_if.next_pc),
    .hit      (l0_hit),
    .hit_line (l0_hit_line)
  );

  gshare_pht pht_i (
    .clk_in     (clk_in),
    .rst_N_in   (rst_N_in),
    .fetch_pc   (pc),
    .train      (x_bcond_resolved),
    .train_pc   (x_pc),
    .train_taken(x_taken),
    .slot_pred  (pd_if.slot_pred)
  );

  branch_predecode predecode_i (
    .pd(pd_if.dec)
  );

endmodule

// ==== branch_pred_assert.sv ====
`timescale 1ns/1ps

module branch_pred_assert (
  input logic clk_in,
  input logic rst_N_in,
  input logic pc_valid,
  input logic l0_valid,
  input logic l1i_req,
  input logic l1i_valid
);

  logic outstanding; // an l1 request has not returned yet
  int   fails = 0;   // failed assertion count

  always_ff @(posedge clk_in) begin
    if (rst_N_in) outstanding <= 1'b0;
    else if (l1i_req) outstanding <= 1'b1;
    else if (l1i_valid) outstanding <= 1'b0;
  end

  a_quiet_after_reset: assert property (@(posedge clk_in)
    $fell(rst_N_in) |-> !pc_valid && !l1i_req)
    else begin
      fails++;
      $error("pc_valid or l1i_req active in the first cycle after reset");
    end

  a_req_pulse: assert property (@(posedge clk_in) disable iff (rst_N_in)
    l1i_req |=> !l1i_req)
    else begin
      fails++;
      $error("l1i_req held high for two cycles");
    end

  a_l0_needs_valid: assert property (@(posedge clk_in) disable iff (rst_N_in)
    l0_valid |-> pc_valid)
    else begin
      fails++;
      $error("l0_valid without pc_valid");
    end

  a_single_req: assert property (@(posedge clk_in) disable iff (rst_N_in)
    l1i_req |-> !outstanding)
    else begin
      fails++;
      $error("new l1i_req while a request is outstanding");
    end

endmodule

// ==== branch_pred_tb.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module branch_pred_tb import bp_pkg::*; ();

  localparam instr_t NOP         = 32'hD503201F;
  localparam instr_t RET         = 32'hD65F03C0;
  localparam int     CYCLE_LIMIT = 6 * 400; // tests times cycles per test

  logic        clk_in, rst_gen, rst_req, rst_N_in;
  logic        l1i_valid, x_bcond_resolved, x_taken, x_pc_incorrect;
  line_t       l1i_line, fetch_line;
  pc_t         x_pc, pred_pc, l1i_addr;
  logic [18:0] x_correction_offset;
  logic        pc_valid, l0_valid, l1i_req;
  slot_mask_t  br_mask, taken_mask;

  instr_t image [pc_t];           // sparse instruction memory
  pc_t    ras_q [$];              // reference return stack, top at the back
  ctr_t   pht_m [pht_idx_t];      // reference counters, missing means 0
  ghr_t   ghr_m;
  pc_t    l0_tag [`BP_L0_SETS];   // line address held per set
  logic [`BP_L0_SETS-1:0] l0_vld;
  int     errors, checks, cycles, req_count, late_extra, lat;
  logic   busy;
  pc_t    req_line;

  assign rst_N_in = rst_gen | rst_req;

  tb_clkgen clkgen_i (.clk_in(clk_in), .rst(rst_gen));
  branch_pred branch_pred_i (.*);

  bind branch_pred branch_pred_assert assert_i (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .pc_valid(pc_valid),
    .l0_valid(l0_valid), .l1i_req(l1i_req), .l1i_valid(l1i_valid)
  );

  function automatic instr_t word_at(input pc_t a);
    return image.exists(a) ? image[a] : NOP;
  endfunction

  function automatic line_t line_at(input pc_t a);
    line_t l;
    pc_t   base;
    base = {a[63:6], 6'b0};
    for (int w = 0; w < 16; w++) l[32*w +: 32] = word_at(base + pc_t'(4 * w));
    return l;
  endfunction

  function automatic instr_t enc_b(input logic link, input pc_t from, input pc_t to);
    pc_t d;
    d = (to - from) >> 2;
    return {link ? 6'b100101 : 6'b000101, d[25:0]};
  endfunction

  function automatic instr_t enc_bcond(input pc_t from, input pc_t to);
    pc_t d;
    d = (to - from) >> 2;
    return {8'h54, d[18:0], 5'b00000}; // cond EQ
  endfunction

  function automatic ctr_t ctr_of(input pc_t a);
    pht_idx_t i;
    i = {ghr_m, a[9:2]};
    return pht_m.exists(i) ? pht_m[i] : 2'b00;
  endfunction

  function automatic logic l0_lookup(input pc_t a);
    return l0_vld[a[8:6]] && (l0_tag[a[8:6]] == {a[63:6], 6'b0});
  endfunction

  // reference prediction for one group, updates the RAS model
  function automatic void predict(input pc_t pc, output pc_t nxt,
                                  output slot_mask_t brm, output slot_mask_t tkm);
    instr_t w;
    pc_t    spc;
    ctr_t   c;
    int     n;
    logic   done;
    brm  = '0;
    tkm  = '0;
    done = 1'b0;
    n    = 0;
    nxt  = pc;
    while (!done && (n < `BP_SLOTS) && ((int'(pc[5:0]) + 4 * n) < 64)) begin
      spc = pc + pc_t'(4 * n);
      w   = word_at(spc);
      c   = ctr_of(spc);
      if (w[31:21] == 11'b11010110010) begin
        brm[n] = 1'b1;
        done   = 1'b1;
        nxt    = (ras_q.size() > 0) ? ras_q.pop_back() : '0;
      end else if (w[30:26] == 5'b00101) begin // B and BL share these bits
        brm[n] = 1'b1;
        done   = 1'b1;
        nxt    = spc + {{36{w[25]}}, w[25:0], 2'b00};
        if (w[31]) begin
          ras_q.push_back(spc + 64'd4);
          if (ras_q.size() > `BP_RAS_DEPTH) void'(ras_q.pop_front()); // oldest lost
        end
      end else if (w[31:24] == 8'h54) begin
        brm[n] = 1'b1;
        if (c[1]) begin
          done = 1'b1;
          nxt  = spc + {{43{w[23]}}, w[23:5], 2'b00};
        end
      end
      if (done) tkm[n] = 1'b1;
      n++;
    end
    if (!done) nxt = pc + pc_t'(4 * n);
  endfunction

  // wait for the next pc_valid and compare it with the model
  task automatic expect_group(inout pc_t pc, inout logic from_l0, input logic chk_l0);
    pc_t        nxt;
    slot_mask_t brm, tkm;
    logic       next_l0;
    predict(pc, nxt, brm, tkm);
    next_l0 = l0_lookup(nxt); // lookup misses a fill made in the same cycle
    if (!from_l0) begin
      l0_vld[pc[8:6]] = 1'b1;
      l0_tag[pc[8:6]] = {pc[63:6], 6'b0};
    end
    @(negedge clk_in);
    while (!pc_valid) @(negedge clk_in);
    checks++;
    assert ((pred_pc == nxt) && (br_mask == brm) && (taken_mask == tkm) &&
            (fetch_line == line_at(pc)) && (!chk_l0 || (l0_valid == from_l0)))
    else begin
      errors++;
      $display("ERROR %0t: group %h pred_pc %h exp %h br %b/%b taken %b/%b l0 %b/%b",
               $time, pc, pred_pc, nxt, br_mask, brm, taken_mask, tkm, l0_valid, from_l0);
    end
    pc      = nxt;
    from_l0 = next_l0;
  endtask

  task automatic run_groups(inout pc_t pc, inout logic from_l0, input int n,
                            input logic chk_l0);
    repeat (n) expect_group(pc, from_l0, chk_l0);
  endtask

  task automatic apply_reset();
    @(posedge clk_in);
    rst_req          <= 1'b1;
    x_bcond_resolved <= 1'b0;
    x_pc_incorrect   <= 1'b0;
    ras_q.delete();
    pht_m.delete();
    ghr_m  = '0;
    l0_vld = '0;
    @(posedge clk_in);
    repeat (9) begin
      @(negedge clk_in);
      checks++;
      assert (!pc_valid && !l0_valid && !l1i_req)
      else begin
        errors++;
        $display("ERROR %0t: outputs active during reset", $time);
      end
    end
    @(posedge clk_in);
    rst_req <= 1'b0;
  endtask

  task automatic redirect(input pc_t base, input logic [18:0] off);
    @(posedge clk_in);
    x_pc                <= base;
    x_correction_offset <= off;
    x_pc_incorrect      <= 1'b1;
    @(posedge clk_in);
    x_pc_incorrect <= 1'b0;
  endtask

  task automatic train(input pc_t a, input logic tk, input int n);
    pht_idx_t i;
    ctr_t     c;
    repeat (n) begin
      @(posedge clk_in);
      x_bcond_resolved <= 1'b1;
      x_taken          <= tk;
      x_pc             <= a;
      i = {ghr_m, a[9:2]};
      c = ctr_of(a);
      if (tk && (c != 2'b11)) c = c + 2'd1;
      else if (!tk && (c != 2'b00)) c = c - 2'd1;
      pht_m[i] = c;
      ghr_m    = {ghr_m[`BP_GHR_K-2:0], tk};
    end
    @(posedge clk_in);
    x_bcond_resolved <= 1'b0;
  endtask

  task automatic check_req(input pc_t addr);
    @(negedge clk_in);
    while (!l1i_req) @(negedge clk_in);
    checks++;
    assert (l1i_addr == addr)
    else begin
      errors++;
      $display("ERROR %0t: l1i_addr %h exp %h", $time, l1i_addr, addr);
    end
  endtask

  task automatic test_reset();
    image.delete();
    image[64'h0] = enc_b(1'b0, 64'h0, 64'h0);
    apply_reset();
    check_req(`BP_RESET_PC);
  endtask

  task automatic test_sequential();
    pc_t  pc;
    logic l0;
    int   reqs;
    image.delete();
    image[64'h1FC] = enc_b(1'b0, 64'h1FC, 64'h38); // lap back into line 0, 2 slots left
    apply_reset();
    pc = `BP_RESET_PC;
    l0 = 1'b0;
    run_groups(pc, l0, 61, 1'b1);
    reqs = req_count;
    run_groups(pc, l0, 29, 1'b1);
    checks++;
    assert (req_count == reqs)
    else begin
      errors++;
      $display("ERROR %0t: %0d l1 requests on an l0 lap", $time, req_count - reqs);
    end
  endtask

  task automatic test_call_ret();
    pc_t  pc;
    logic l0;
    image.delete();
    image[64'h0]   = enc_b(1'b1, 64'h0, 64'h100);
    image[64'h100] = enc_b(1'b1, 64'h100, 64'h200);
    image[64'h200] = RET;
    image[64'h104] = RET;
    image[64'h4]   = enc_b(1'b0, 64'h4, 64'h4);
    apply_reset();
    pc = `BP_RESET_PC;
    l0 = 1'b0;
    run_groups(pc, l0, 8, 1'b1);
  endtask

  task automatic test_bcond();
    pc_t  pc;
    logic l0;
    image.delete();
    image[64'h0]   = enc_b(1'b0, 64'h0, 64'h0); // idle loop
    image[64'h300] = enc_bcond(64'h300, 64'h380);
    image[64'h308] = enc_b(1'b0, 64'h308, 64'h500);
    image[64'h380] = enc_b(1'b0, 64'h380, 64'h380);
    image[64'h500] = enc_b(1'b0, 64'h500, 64'h500);
    apply_reset();
    for (int step = 0; step < 4; step++) begin
      if (step == 1) train(64'h300, 1'b1, 10);  // history fills with ones first
      if (step == 2) train(64'h300, 1'b1, 10);  // pinned at strongly taken
      if (step == 3) train(64'h300, 1'b0, 10);  // back down to zero
      redirect(64'h300, 19'h0);
      pc = 64'h300;
      l0 = 1'b0;
      run_groups(pc, l0, 2, 1'b0);
    end
  endtask

  task automatic test_redirect_pending();
    pc_t  pc;
    logic l0;
    image.delete();
    image[64'h0]   = enc_b(1'b0, 64'h0, 64'h0);
    image[64'h844] = enc_b(1'b0, 64'h844, 64'h900);
    image[64'h900] = enc_b(1'b0, 64'h900, 64'h900);
    late_extra = 3;
    apply_reset();
    check_req(`BP_RESET_PC);
    redirect(64'h800, 19'h40);
    late_extra = 0;
    pc = 64'h840;
    l0 = 1'b0;
    run_groups(pc, l0, 2, 1'b0);
  endtask

  task automatic test_redirect_idle();
    pc_t  pc;
    logic l0;
    image.delete();
    image[64'hC] = enc_b(1'b0, 64'hC, 64'h0);
    apply_reset();
    @(negedge clk_in);
    while (!l0_valid) @(negedge clk_in); // streaming out of l0
    redirect(64'hC10, 19'h7FFF0);          // minus 16
    check_req(64'hC00);
    pc = 64'hC00;
    l0 = 1'b0;
    run_groups(pc, l0, 2, 1'b0);
  endtask

  // L1I model, one request at a time
  always @(posedge clk_in) begin
    l1i_valid <= 1'b0;
    if (rst_N_in) begin
      busy <= 1'b0;
    end else if (busy) begin
      if (lat <= 1) begin
        busy      <= 1'b0;
        l1i_valid <= 1'b1;
        l1i_line  <= line_at(req_line);
      end else begin
        lat <= lat - 1;
      end
    end else if (l1i_req) begin
      busy     <= 1'b1;
      req_line <= l1i_addr;
      lat      <= 1 + int'($urandom_range(3)) + late_extra;
      req_count++;
    end
  end

  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(49));
    rst_req             = 1'b0;
    l1i_valid           = 1'b0;
    l1i_line            = '0;
    x_bcond_resolved    = 1'b0;
    x_taken             = 1'b0;
    x_pc                = '0;
    x_pc_incorrect      = 1'b0;
    x_correction_offset = '0;
    errors              = 0;
    checks              = 0;
    cycles              = 0;
    req_count           = 0;
    late_extra          = 0;
    busy                = 1'b0;
    lat                 = 0;
    test_reset();
    test_sequential();
    test_call_ret();
    test_bcond();
    test_redirect_pending();
    test_redirect_idle();
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, branch_pred_i.assert_i.fails);
    if ((errors == 0) && (branch_pred_i.assert_i.fails == 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== branch_predecode.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module branch_predecode import bp_pkg::*; (
  bp_predecode_if.dec pd
);

  localparam int PAD26 = `BP_PC_W - 28; // sign bits above imm26 * 4
  localparam int PAD19 = `BP_PC_W - 21; // sign bits above imm19 * 4

  always_comb begin : scan
    int unsigned off;     // byte offset of the slot in the line
    int unsigned scanned; // slots that fit in the line
    logic        stop;
    instr_t      instr;
    pc_t         slot_pc;
    pc_t         target;

    off     = 0;
    scanned = 0;
    stop    = 1'b0;
    instr   = '0;
    slot_pc = '0;
    target  = '0;

    pd.br_mask    = '0;
    pd.taken_mask = '0;
    pd.ras_push   = 1'b0;
    pd.ras_pop    = 1'b0;
    pd.push_addr  = '0;

    for (int i = 0; i < `BP_SLOTS; i++) begin
      off = int'(pd.fetch_pc[5:0]) + 4 * i;
      if (!stop && (off < `BP_LINE_BYTES)) begin
        scanned = scanned + 1;
        instr   = pd.line[off*8 +: 32];
        slot_pc = pd.fetch_pc + pc_t'(4 * i);

        if (instr[31:21] == 11'b11010110010) begin // RET
          pd.br_mask[i] = 1'b1;
          pd.ras_pop    = 1'b1;
          target        = pd.ras_top;
          stop          = 1'b1;
        end else if ((instr[31:26] == 6'b000101) || (instr[31:26] == 6'b100101)) begin
          // B or BL, word offset in imm26
          pd.br_mask[i] = 1'b1;
          target = slot_pc + {{PAD26{instr[25]}}, instr[25:0], 2'b00};
          stop   = 1'b1;
          if (instr[31]) begin // BL links
            pd.ras_push  = 1'b1;
            pd.push_addr = slot_pc + pc_t'(4);
          end
        end else if (instr[31:24] == 8'b01010100) begin // B.cond
          pd.br_mask[i] = 1'b1;
          if (pd.slot_pred[i]) begin // only a predicted-taken one ends the group
            target = slot_pc + {{PAD19{instr[23]}}, instr[23:5], 2'b00};
            stop   = 1'b1;
          end
        end

        if (stop) pd.taken_mask[i] = 1'b1;
      end
    end

    // fall through covers only the slots left in the line
    if (stop) pd.next_pc = target;
    else      pd.next_pc = pd.fetch_pc + pc_t'(scanned * 4);
  end

endmodule

// ==== gshare_pht.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module gshare_pht import bp_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_N_in,
  input  pc_t        fetch_pc,
  input  logic       train,
  input  pc_t        train_pc,
  input  logic       train_taken,
  output slot_mask_t slot_pred
);

  localparam int PHT_SIZE = 1 << (`BP_GHR_K + `BP_PHT_N);

  ctr_t     pht [PHT_SIZE];
  ghr_t     ghr;
  pht_idx_t train_idx;
  ctr_t     train_ctr;
  ctr_t     ctr_nxt;

  // history on top, word address bits below
  function automatic pht_idx_t pht_index(input pc_t pc, input ghr_t hist);
    return {hist, pc[`BP_PHT_N+1:2]};
  endfunction

  // per-slot lookup, msb of the counter is the taken guess
  always_comb begin
    for (int i = 0; i < `BP_SLOTS; i++) begin
      slot_pred[i] = pht[pht_index(fetch_pc + pc_t'(4 * i), ghr)][1];
    end
  end

  assign train_idx = pht_index(train_pc, ghr);
  assign train_ctr = pht[train_idx];

  always_comb begin
    ctr_nxt = train_ctr;
    if (train_taken && (train_ctr != 2'b11)) ctr_nxt = train_ctr + 1'b1;     // saturate high
    else if (!train_taken && (train_ctr != 2'b00)) ctr_nxt = train_ctr - 1'b1; // saturate low
  end

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      pht <= '{default: '0}; // all strongly not-taken
      ghr <= '0;
    end else if (train) begin
      pht[train_idx] <= ctr_nxt;
      ghr            <= {ghr[`BP_GHR_K-2:0], train_taken}; // newest in bit 0
    end
  end

endmodule

// ==== l0_icache.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module l0_icache import bp_pkg::*; #(
  parameter int SETS = 8
) (
  input  logic  clk_in,
  input  logic  rst_N_in,
  input  logic  fill,
  input  pc_t   fill_addr,
  input  line_t fill_line,
  input  pc_t   lookup_pc,
  output logic  hit,
  output line_t hit_line
);

  localparam int OW = $clog2(`BP_LINE_BYTES); // byte offset bits
  localparam int IW = $clog2(SETS);           // set index bits
  localparam int TW = `BP_PC_W - OW - IW;     // tag bits

  logic [SETS-1:0] valid;
  logic [TW-1:0]   tag_mem  [SETS];
  line_t           line_mem [SETS];

  logic [IW-1:0] fill_set;
  logic [IW-1:0] look_set;
  logic [TW-1:0] fill_tag;
  logic [TW-1:0] look_tag;

  // split the addresses
  assign fill_set = fill_addr[OW +: IW];
  assign fill_tag = fill_addr[`BP_PC_W-1 -: TW];
  assign look_set = lookup_pc[OW +: IW];
  assign look_tag = lookup_pc[`BP_PC_W-1 -: TW];

  // combinational lookup against the stored state only
  assign hit      = valid[look_set] && (tag_mem[look_set] == look_tag);
  assign hit_line = line_mem[look_set];

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      valid <= '0;
    end else if (fill) begin
      valid[fill_set] <= 1'b1;
    end
  end

  // tag and data arrays
  always_ff @(posedge clk_in) begin
    if (fill) begin
      tag_mem[fill_set]  <= fill_tag;
      line_mem[fill_set] <= fill_line;
    end
  end

endmodule

// ==== ras_stack.sv ====
`timescale 1ns/1ps

module ras_stack import bp_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic clk_in,
  input  logic rst_N_in,
  input  logic push,
  input  logic pop,
  input  pc_t  push_addr,
  output pc_t  top
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] FULL = (AW+1)'(DEPTH);

  pc_t         mem [DEPTH];
  logic [AW-1:0] head;    // next free slot, wraps around
  logic [AW-1:0] top_idx;
  logic [AW:0]   count;   // saturates at DEPTH

  assign top_idx = head - 1'b1;
  assign top     = (count == '0) ? '0 : mem[top_idx]; // empty reads as zero

  always_ff @(posedge clk_in) begin
    if (rst_N_in) begin
      head  <= '0;
      count <= '0;
    end else if (push) begin
      head <= head + 1'b1; // full push drops the oldest entry
      if (count != FULL) count <= count + 1'b1;
    end else if (pop && (count != '0)) begin
      head  <= top_idx;
      count <= count - 1'b1;
    end
  end

  // entry storage
  always_ff @(posedge clk_in) begin
    if (push) mem[head] <= push_addr;
  end

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_in,
  output logic rst
);

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in; // 4 ns period
  end

  // power-on reset, high for 10 cycles
  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk_in);
    rst <= 1'b0;
  end

endmodule
